// ==== hdl/lvds_if_pkg.sv ====
package lvds_if_pkg;

  // ********************************************************************
  // lvds port geometry
  // ********************************************************************

  // data lanes per ddr half
  localparam int lane_w = 6;
  // one word is a falling half over a rising half
  localparam int word_w = 2 * lane_w;
  // rf1 i/q in the lower half, rf2 i/q in the upper half
  localparam int sample_w = 48;
  localparam int chan_w = 24;

  // ********************************************************************
  // frame window codes
  // ********************************************************************

  // older 2-bit frame in [3:2], newer 2-bit frame in [1:0]
  typedef logic [3:0] frame_win_t;

  // r1 capture point, previous word framed high and current word low
  localparam frame_win_t win_r1_valid = 4'b1100;
  // low to high transition, legal in both modes
  localparam frame_win_t win_r1_alt = 4'b0011;
  // r2 rf1 capture
  localparam frame_win_t win_r2_first = 4'b1111;
  // r2 rf2 capture and word complete
  localparam frame_win_t win_r2_valid = 4'b0000;

  // ********************************************************************
  // sequencing
  // ********************************************************************

  // symbol pairs per sample word on transmit
  localparam int tx_symbols = 4;
  // cycles per frame alignment check
  localparam int align_period = 4;
  // processor control synchronizer depth
  localparam int sync_stages = 2;

endpackage

// ==== hdl/rx_frame_align.sv ====
`timescale 1ns/1ps

module rx_frame_align import lvds_if_pkg::*; (
  input  logic              l_clk,
  input  logic              rst,
  input  logic [lane_w-1:0] rx_data_p,
  input  logic [lane_w-1:0] rx_data_n,
  input  logic              rx_frame_p,
  input  logic              rx_frame_n,
  output logic [word_w-1:0] rx_word,
  output logic [word_w-1:0] rx_word_d,
  output frame_win_t        rx_win
);

  localparam int cnt_w = $clog2(align_period);

  logic [lane_w-1:0] data_p_q;
  logic [lane_w-1:0] data_n_q;
  logic [lane_w-1:0] data_p_d;
  logic              frame_p_q;
  logic              frame_n_q;
  logic              frame_p_d;
  logic [cnt_w-1:0]  align_cnt;
  logic              skew_seen;
  logic              misalign;
  logic              frame_skew;
  logic [1:0]        frame_q;
  logic [1:0]        frame_d;

  // both frame halves should carry the same level when aligned
  assign frame_skew = frame_p_q ^ frame_n_q;
  assign rx_win = {frame_d, frame_q};

  // ddr capture stage
  always_ff @(posedge l_clk) begin
    data_p_q <= rx_data_p;
    data_n_q <= rx_data_n;
    data_p_d <= data_p_q;
  end

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      frame_p_q <= 1'b0;
      frame_n_q <= 1'b0;
      frame_p_d <= 1'b0;
      align_cnt <= '0;
      skew_seen <= 1'b0;
      misalign <= 1'b0;
    end else begin
      frame_p_q <= rx_frame_p;
      frame_n_q <= rx_frame_n;
      frame_p_d <= frame_p_q;
      // any skew within the window marks the port as shifted by half a cycle
      if (align_cnt == cnt_w'(align_period - 1)) begin
        align_cnt <= '0;
        misalign <= skew_seen | frame_skew;
        skew_seen <= 1'b0;
      end else begin
        align_cnt <= align_cnt + 1'b1;
        skew_seen <= skew_seen | frame_skew;
      end
    end
  end

  // word assembly, misaligned pairs the previous rising half with this falling half
  always_ff @(posedge l_clk) begin
    if (misalign) begin
      rx_word <= {data_p_d, data_n_q};
    end else begin
      rx_word <= {data_n_q, data_p_q};
    end
    rx_word_d <= rx_word;
  end

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      frame_q <= 2'b00;
      frame_d <= 2'b00;
    end else begin
      frame_q <= misalign ? {frame_p_d, frame_n_q} : {frame_n_q, frame_p_q};
      frame_d <= frame_q;
    end
  end

endmodule

// ==== hdl/rx_deframer.sv ====
`timescale 1ns/1ps

module rx_deframer import lvds_if_pkg::*; (
  input  logic                l_clk,
  input  logic                rst,
  input  logic [word_w-1:0]   rx_word,
  input  logic [word_w-1:0]   rx_word_d,
  input  frame_win_t          rx_win,
  input  logic                adc_r1_mode,
  output logic                adc_valid,
  output logic [sample_w-1:0] adc_data,
  output logic                adc_status
);

  logic [chan_w-1:0]   chan_s;
  logic                r1_hit;
  logic                r1_legal;
  logic                r2_first_hit;
  logic                r2_hit;
  logic                r2_legal;
  logic                valid_r1;
  logic                valid_r2;
  logic                status_r1;
  logic                status_r2;
  logic                sel_valid;
  logic [chan_w-1:0]   data_r1;
  logic [sample_w-1:0] data_r2;

  // ********************************************************************
  // window decode
  // ********************************************************************

  // high halves form the lower 12 bits, low halves the upper 12 bits
  assign chan_s = {rx_word_d[lane_w-1:0], rx_word[lane_w-1:0],
                   rx_word_d[word_w-1:lane_w], rx_word[word_w-1:lane_w]};

  assign r1_hit = (rx_win == win_r1_valid);
  assign r1_legal = r1_hit || (rx_win == win_r1_alt);
  assign r2_first_hit = (rx_win == win_r2_first);
  assign r2_hit = (rx_win == win_r2_valid);
  assign r2_legal = r1_legal || r2_first_hit || r2_hit;

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      valid_r1 <= 1'b0;
      valid_r2 <= 1'b0;
      status_r1 <= 1'b0;
      status_r2 <= 1'b0;
    end else begin
      valid_r1 <= r1_hit;
      valid_r2 <= r2_hit;
      status_r1 <= r1_legal;
      status_r2 <= r2_legal;
    end
  end

  // channel capture
  always_ff @(posedge l_clk) begin
    if (r1_hit) begin
      data_r1 <= chan_s;
    end
    // rf1 lands first, rf2 completes the r2 word
    if (r2_first_hit) begin
      data_r2[chan_w-1:0] <= chan_s;
    end
    if (r2_hit) begin
      data_r2[sample_w-1:chan_w] <= chan_s;
    end
  end

  // ********************************************************************
  // mode select
  // ********************************************************************

  assign sel_valid = adc_r1_mode ? valid_r1 : valid_r2;

  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      adc_valid <= 1'b0;
      adc_status <= 1'b0;
    end else begin
      adc_valid <= sel_valid;
      adc_status <= adc_r1_mode ? status_r1 : status_r2;
    end
  end

  // data holds between valids
  always_ff @(posedge l_clk) begin
    if (sel_valid) begin
      adc_data <= adc_r1_mode ? {{(sample_w - chan_w){1'b0}}, data_r1} : data_r2;
    end
  end

endmodule

// ==== hdl/tx_framer.sv ====
`timescale 1ns/1ps

module tx_framer import lvds_if_pkg::*; (
  input  logic                l_clk,
  input  logic                rst,
  input  logic                dac_valid,
  input  logic [sample_w-1:0] dac_data,
  input  logic                dac_r1_mode,
  output logic [lane_w-1:0]   tx_data_p,
  output logic [lane_w-1:0]   tx_data_n,
  output logic                tx_frame
);

  localparam int cnt_w = $clog2(tx_symbols);

  logic [sample_w-1:0] tx_sample;
  logic                active;
  logic [cnt_w-1:0]    sym_cnt;
  logic                last_sym;
  logic [cnt_w:0]      sel_s;

  assign last_sym = (sym_cnt == cnt_w'(tx_symbols - 1));
  // mode bit over the symbol index
  assign sel_s = {dac_r1_mode, sym_cnt};

  always_ff @(posedge l_clk) begin
    if (dac_valid) begin
      tx_sample <= dac_data;
    end
  end

  // ********************************************************************
  // symbol sequencer
  // ********************************************************************

  // a new strobe restarts the sequence from the first pair
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      active <= 1'b0;
      sym_cnt <= '0;
    end else if (dac_valid) begin
      active <= 1'b1;
      sym_cnt <= '0;
    end else if (active) begin
      sym_cnt <= sym_cnt + 1'b1;
      if (last_sym) begin
        active <= 1'b0;
      end
    end
  end

  // r1 sends the lower channel twice
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      tx_data_p <= '0;
      tx_data_n <= '0;
      tx_frame <= 1'b0;
    end else if (!active) begin
      tx_data_p <= '0;
      tx_data_n <= '0;
      tx_frame <= 1'b0;
    end else begin
      case (sel_s)
        3'b100, 3'b110: begin
          tx_data_p <= tx_sample[11:6];
          tx_data_n <= tx_sample[23:18];
          tx_frame <= 1'b1;
        end
        3'b101, 3'b111: begin
          tx_data_p <= tx_sample[5:0];
          tx_data_n <= tx_sample[17:12];
          tx_frame <= 1'b0;
        end
        // r2 keeps the frame high across both rf1 pairs
        3'b000: begin
          tx_data_p <= tx_sample[11:6];
          tx_data_n <= tx_sample[23:18];
          tx_frame <= 1'b1;
        end
        3'b001: begin
          tx_data_p <= tx_sample[5:0];
          tx_data_n <= tx_sample[17:12];
          tx_frame <= 1'b1;
        end
        3'b010: begin
          tx_data_p <= tx_sample[35:30];
          tx_data_n <= tx_sample[47:42];
          tx_frame <= 1'b0;
        end
        default: begin
          tx_data_p <= tx_sample[29:24];
          tx_data_n <= tx_sample[41:36];
          tx_frame <= 1'b0;
        end
      endcase
    end
  end

  a_idle_frame_low: assert property (
    @(posedge l_clk) disable iff (rst) !active |-> !tx_frame);

endmodule

// ==== hdl/ensm_ctrl.sv ====
`timescale 1ns/1ps

module ensm_ctrl import lvds_if_pkg::*; (
  input  logic l_clk,
  input  logic rst,
  input  logic up_enable,
  input  logic up_txnrx,
  input  logic tdd_enable,
  input  logic tdd_txnrx,
  input  logic tdd_mode,
  output logic enable,
  output logic txnrx
);

  logic [sync_stages-1:0] enable_sync;
  logic [sync_stages-1:0] txnrx_sync;

  // processor requests arrive asynchronously
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      enable_sync <= '0;
      txnrx_sync <= '0;
    end else begin
      enable_sync <= {enable_sync[sync_stages-2:0], up_enable};
      txnrx_sync <= {txnrx_sync[sync_stages-2:0], up_txnrx};
    end
  end

  // tdd controller takes over the ensm pins in tdd mode
  always_ff @(posedge l_clk or posedge rst) begin
    if (rst) begin
      enable <= 1'b0;
      txnrx <= 1'b0;
    end else begin
      enable <= tdd_mode ? tdd_enable : enable_sync[sync_stages-1];
      txnrx <= tdd_mode ? tdd_txnrx : txnrx_sync[sync_stages-1];
    end
  end

  a_ensm_known: assert property (
    @(posedge l_clk) disable iff (rst) !$isunknown({enable, txnrx}));

endmodule

// ==== hdl/ad9361_lvds_if.sv ====
`timescale 1ns/1ps

module ad9361_lvds_if import lvds_if_pkg::*; (
  input  logic                l_clk,
  input  logic                rst,
  // receive port
  input  logic [lane_w-1:0]   rx_data_p,
  input  logic [lane_w-1:0]   rx_data_n,
  input  logic                rx_frame_p,
  input  logic                rx_frame_n,
  input  logic                adc_r1_mode,
  output logic                adc_valid,
  output logic [sample_w-1:0] adc_data,
  output logic                adc_status,
  // transmit port
  input  logic                dac_valid,
  input  logic [sample_w-1:0] dac_data,
  input  logic                dac_r1_mode,
  output logic [lane_w-1:0]   tx_data_p,
  output logic [lane_w-1:0]   tx_data_n,
  output logic                tx_frame,
  // ensm control
  input  logic                up_enable,
  input  logic                up_txnrx,
  input  logic                tdd_enable,
  input  logic                tdd_txnrx,
  input  logic                tdd_mode,
  output logic                enable,
  output logic                txnrx
);

  logic [word_w-1:0] rx_word;
  logic [word_w-1:0] rx_word_d;
  frame_win_t        rx_win;

  // ********************************************************************
  // receive, transmit and control paths
  // ********************************************************************

  rx_frame_align rx_frame_align_i (
    .l_clk(l_clk), .rst(rst), .rx_data_p(rx_data_p), .rx_data_n(rx_data_n),
    .rx_frame_p(rx_frame_p), .rx_frame_n(rx_frame_n),
    .rx_word(rx_word), .rx_word_d(rx_word_d), .rx_win(rx_win));

  rx_deframer rx_deframer_i (
    .l_clk(l_clk), .rst(rst), .rx_word(rx_word), .rx_word_d(rx_word_d),
    .rx_win(rx_win), .adc_r1_mode(adc_r1_mode),
    .adc_valid(adc_valid), .adc_data(adc_data), .adc_status(adc_status));

  tx_framer tx_framer_i (
    .l_clk(l_clk), .rst(rst), .dac_valid(dac_valid), .dac_data(dac_data),
    .dac_r1_mode(dac_r1_mode),
    .tx_data_p(tx_data_p), .tx_data_n(tx_data_n), .tx_frame(tx_frame));

  ensm_ctrl ensm_ctrl_i (
    .l_clk(l_clk), .rst(rst), .up_enable(up_enable), .up_txnrx(up_txnrx),
    .tdd_enable(tdd_enable), .tdd_txnrx(tdd_txnrx), .tdd_mode(tdd_mode),
    .enable(enable), .txnrx(txnrx));

endmodule

// ==== sim/tb_ad9361_lvds_if.sv ====
`timescale 1ns/1ps

module tb_ad9361_lvds_if import lvds_if_pkg::*; ();

  localparam int n_words = 8;
  localparam int loop_cycles = 4 * n_words + 8;
  localparam int err_cycles = 16;
  localparam int align_cycles = 48;
  // alignment decision plus pipeline fill before data is trusted
  localparam int align_settle = 2 * align_period + 12;
  localparam int total_cycles = 8 + 2 * (loop_cycles + 9) + (err_cycles + 5) +
                                (align_cycles + 5) + 16;

  logic                l_clk;
  logic                rst;
  logic [lane_w-1:0]   rx_data_p;
  logic [lane_w-1:0]   rx_data_n;
  logic                rx_frame_p;
  logic                rx_frame_n;
  logic                adc_r1_mode;
  logic                adc_valid;
  logic [sample_w-1:0] adc_data;
  logic                adc_status;
  logic                dac_valid;
  logic [sample_w-1:0] dac_data;
  logic                dac_r1_mode;
  logic [lane_w-1:0]   tx_data_p;
  logic [lane_w-1:0]   tx_data_n;
  logic                tx_frame;
  logic                up_enable;
  logic                up_txnrx;
  logic                tdd_enable;
  logic                tdd_txnrx;
  logic                tdd_mode;
  logic                enable;
  logic                txnrx;

  logic                loopback;
  logic [lane_w-1:0]   drv_data_p;
  logic [lane_w-1:0]   drv_data_n;
  logic                drv_frame_p;
  logic                drv_frame_n;
  logic [sample_w-1:0] words [n_words];
  integer              seed;
  int                  errors;
  int                  pulses;
  int                  words_sent;

  // loopback sends the single tx frame on both rx frame halves
  assign rx_data_p = loopback ? tx_data_p : drv_data_p;
  assign rx_data_n = loopback ? tx_data_n : drv_data_n;
  assign rx_frame_p = loopback ? tx_frame : drv_frame_p;
  assign rx_frame_n = loopback ? tx_frame : drv_frame_n;

  ad9361_lvds_if dut_i (
    .l_clk(l_clk), .rst(rst), .rx_data_p(rx_data_p), .rx_data_n(rx_data_n),
    .rx_frame_p(rx_frame_p), .rx_frame_n(rx_frame_n), .adc_r1_mode(adc_r1_mode),
    .adc_valid(adc_valid), .adc_data(adc_data), .adc_status(adc_status),
    .dac_valid(dac_valid), .dac_data(dac_data), .dac_r1_mode(dac_r1_mode),
    .tx_data_p(tx_data_p), .tx_data_n(tx_data_n), .tx_frame(tx_frame),
    .up_enable(up_enable), .up_txnrx(up_txnrx), .tdd_enable(tdd_enable),
    .tdd_txnrx(tdd_txnrx), .tdd_mode(tdd_mode), .enable(enable), .txnrx(txnrx));

  initial begin
    l_clk = 1'b0;
    forever #5 l_clk = ~l_clk;
  end

  // ********************************************************************
  // helpers
  // ********************************************************************

  task automatic report_mismatch(input string name, input logic [sample_w-1:0] got,
                                 input logic [sample_w-1:0] exp);
    errors++;
    $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  function automatic logic [sample_w-1:0] rand_sample();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[sample_w-1:0];
  endfunction

  // a channel comes back with its two 12-bit halves exchanged
  function automatic logic [chan_w-1:0] swap_halves(input logic [chan_w-1:0] c);
    return {c[word_w-1:0], c[chan_w-1:word_w]};
  endfunction

  function automatic logic [sample_w-1:0] exp_r1(input logic [sample_w-1:0] s);
    return {{(sample_w - chan_w){1'b0}}, swap_halves(s[chan_w-1:0])};
  endfunction

  function automatic logic [sample_w-1:0] exp_r2(input logic [sample_w-1:0] s);
    return {swap_halves(s[sample_w-1:chan_w]), swap_halves(s[chan_w-1:0])};
  endfunction

  // r2 symbol pair as {frame, falling half, rising half}
  function automatic logic [12:0] r2_symbol(input logic [sample_w-1:0] s, input int pos);
    case (pos)
      0: return {1'b1, s[23:18], s[11:6]};
      1: return {1'b1, s[17:12], s[5:0]};
      2: return {1'b0, s[47:42], s[35:30]};
      default: return {1'b0, s[41:36], s[29:24]};
    endcase
  endfunction

  // r1 pattern with the frame stuck high for 3 cycles from cycle 8
  function automatic logic err_frame(input int c);
    if (c < 0 || c >= err_cycles) begin
      return 1'b0;
    end
    return (c >= 8 && c < 11) ? 1'b1 : (c % 2 == 0);
  endfunction

  // ********************************************************************
  // directed tests
  // ********************************************************************

  task automatic check_reset();
    if ({adc_valid, adc_status, tx_frame, enable, txnrx} !== 5'b0)
      report_mismatch("{adc_valid,adc_status,tx_frame,enable,txnrx}",
                      48'({adc_valid, adc_status, tx_frame, enable, txnrx}), 48'h0);
  endtask

  // outputs seen at the negedge after edge e, strobes sampled at edges 0, 4, 8 ...
  task automatic run_loopback(input logic r1);
    int e;
    int first;
    logic exp_v;
    logic [sample_w-1:0] s;
    logic [sample_w-1:0] exp_d;
    adc_r1_mode = r1;
    dac_r1_mode = r1;
    loopback = 1'b1;
    first = r1 ? 6 : 8;
    for (int i = 0; i < n_words; i++) begin
      words[i] = rand_sample();
    end
    repeat (8) @(negedge l_clk);
    for (int c = 0; c < loop_cycles; c++) begin
      e = c - 1;
      if (e >= 5 && e <= 4 * n_words + 4) begin
        exp_v = (e >= first) && ((e - first) % (r1 ? 2 : 4) == 0);
        if (adc_status !== 1'b1) report_mismatch("adc_status", 48'(adc_status), 48'h1);
        if (adc_valid !== exp_v) report_mismatch("adc_valid", 48'(adc_valid), 48'(exp_v));
        if (exp_v) begin
          s = words[(e - first) / 4];
          exp_d = r1 ? exp_r1(s) : exp_r2(s);
          pulses++;
          if (adc_data !== exp_d) report_mismatch("adc_data", adc_data, exp_d);
        end
      end
      dac_valid = (c % 4 == 0) && (c < 4 * n_words);
      if (dac_valid) begin
        dac_data = words[c / 4];
      end else begin
        dac_data = rand_sample();
      end
      @(negedge l_clk);
    end
    words_sent += n_words;
    loopback = 1'b0;
  endtask

  task automatic run_frame_error();
    int e;
    logic [sample_w-1:0] r;
    logic f_old;
    logic f_new;
    adc_r1_mode = 1'b1;
    for (int c = 0; c < err_cycles + 4; c++) begin
      e = c - 1;
      if (e >= 5 && e <= err_cycles + 2) begin
        f_old = err_frame(e - 4);
        f_new = err_frame(e - 3);
        if (adc_status !== (f_old ^ f_new))
          report_mismatch("adc_status", 48'(adc_status), 48'(f_old ^ f_new));
        if (adc_valid !== (f_old & ~f_new))
          report_mismatch("adc_valid", 48'(adc_valid), 48'(f_old & ~f_new));
      end
      r = rand_sample();
      drv_data_p = r[5:0];
      drv_data_n = r[11:6];
      drv_frame_p = err_frame(c);
      drv_frame_n = err_frame(c);
      @(negedge l_clk);
    end
  endtask

  // the port is shifted by half a cycle, rising lanes carry the next symbol
  task automatic run_alignment();
    int e;
    logic exp_v;
    logic [12:0] cur;
    logic [12:0] nxt;
    logic [sample_w-1:0] s [align_cycles / 4 + 1];
    adc_r1_mode = 1'b0;
    for (int i = 0; i <= align_cycles / 4; i++) begin
      s[i] = rand_sample();
    end
    for (int c = 0; c < align_cycles + 4; c++) begin
      e = c - 1;
      if (e >= align_settle && e <= align_cycles + 2) begin
        exp_v = (e % 4 == 2);
        if (adc_status !== 1'b1) report_mismatch("adc_status", 48'(adc_status), 48'h1);
        if (adc_valid !== exp_v) report_mismatch("adc_valid", 48'(adc_valid), 48'(exp_v));
        if (exp_v && adc_data !== exp_r2(s[(e - 3) / 4]))
          report_mismatch("adc_data", adc_data, exp_r2(s[(e - 3) / 4]));
        pulses += int'(exp_v);
      end
      if (c < align_cycles) begin
        cur = r2_symbol(s[c / 4], c % 4);
        nxt = r2_symbol(s[(c + 1) / 4], (c + 1) % 4);
        drv_data_p = nxt[11:6];
        drv_data_n = cur[5:0];
        drv_frame_p = nxt[12];
        drv_frame_n = cur[12];
      end else begin
        {drv_data_p, drv_data_n, drv_frame_p, drv_frame_n} = '0;
      end
      @(negedge l_clk);
    end
  endtask

  task automatic run_ensm();
    logic [1:0] v;
    logic [1:0] prev;
    tdd_mode = 1'b1;
    for (int i = 0; i < 4; i++) begin
      v = i[1:0];
      tdd_enable = v[1];
      tdd_txnrx = v[0];
      @(negedge l_clk);
      if ({enable, txnrx} !== v) report_mismatch("{enable,txnrx}", 48'({enable, txnrx}), 48'(v));
    end
    // processor path lags by the synchronizer plus the output register
    tdd_mode = 1'b0;
    prev = 2'b00;
    for (int i = 1; i < 4; i++) begin
      v = i[1:0];
      up_enable = v[1];
      up_txnrx = v[0];
      repeat (2) @(negedge l_clk);
      if ({enable, txnrx} !== prev)
        report_mismatch("{enable,txnrx}", 48'({enable, txnrx}), 48'(prev));
      @(negedge l_clk);
      if ({enable, txnrx} !== v) report_mismatch("{enable,txnrx}", 48'({enable, txnrx}), 48'(v));
      prev = v;
    end
  endtask

  // ********************************************************************
  // sequence and watchdog
  // ********************************************************************

  initial begin
    seed = 33;
    errors = 0;
    pulses = 0;
    words_sent = 0;
    rst = 1'b1;
    {dac_valid, dac_data, up_enable, up_txnrx} = '0;
    {tdd_enable, tdd_txnrx, tdd_mode, loopback} = '0;
    {drv_data_p, drv_data_n, drv_frame_p, drv_frame_n} = '0;
    // r1 during reset, idle r2 windows would read as valid words
    adc_r1_mode = 1'b1;
    dac_r1_mode = 1'b1;
    repeat (3) @(posedge l_clk);
    @(negedge l_clk);
    rst = 1'b0;
    @(negedge l_clk);
    check_reset();
    run_loopback(1'b1);
    run_loopback(1'b0);
    run_frame_error();
    run_alignment();
    run_ensm();
    $display("words sent: %0d, valid pulses checked: %0d, errors: %0d",
             words_sent, pulses, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(total_cycles * 10 + 200);
    $display("timeout: tests did not finish within %0d ns", total_cycles * 10 + 200);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== ad9361_lvds_if.f ====
hdl/lvds_if_pkg.sv
hdl/rx_frame_align.sv
hdl/rx_deframer.sv
hdl/tx_framer.sv
hdl/ensm_ctrl.sv
hdl/ad9361_lvds_if.sv
sim/tb_ad9361_lvds_if.sv

// ==== Makefile ====
SIM        = verilator
TOP        = tb_ad9361_lvds_if
FILELIST   = ad9361_lvds_if.f
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = >>> FAIL
PASS_MSG   = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
